//--- common/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// instruction word width
`define DEC_ILEN            32

// pc keeps bits DEC_PC_BITS-1 down to 1 of the address space
`define DEC_PC_BITS         32

`define DEC_REG_IDX_BITS    5

`define DEC_CSR_IDX_BITS    12

`endif

//--- common/rv_decode_pkg.sv
`include "rv_decode_config.svh"

package rv_decode_pkg;

    typedef logic [`DEC_ILEN-1:0]           instr_t;
    typedef logic [`DEC_PC_BITS-1:1]        pc_t;
    typedef logic [`DEC_REG_IDX_BITS-1:0]   reg_idx_t;
    typedef logic [`DEC_ILEN-1:0]           imm_t;
    typedef logic [`DEC_CSR_IDX_BITS-1:0]   csr_idx_t;
    typedef logic [2:0]                     funct3_t;

    // low two bits of every 32-bit encoding
    localparam logic [1:0] OPC_FULL = 2'b11;

    // major opcodes from instruction bits 6..2
    typedef enum logic [4:0]
    {
        LOAD     = 5'b00000,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } opcode_e;

    typedef enum logic [2:0]
    {
        NONE  = 3'd0,
        ARITH = 3'd1,
        CMP   = 3'd2,
        BITS  = 3'd3,
        SHIFT = 3'd4
    } alu_unit_e;

    // writeback source
    typedef enum logic [1:0]
    {
        ALU     = 2'd0,
        MEMORY  = 2'd1,
        PC_NEXT = 2'd2
    } res_src_e;

    typedef enum logic [1:0]
    {
        REG  = 2'd0,
        IMM  = 2'd1,
        JUMP = 2'd2
    } op2_src_e;

endpackage

//--- common/decode_if.sv
`timescale 1ns/1ps

// registered instruction and its pcs
interface dec_instr_if;
    import rv_decode_pkg::*;

    instr_t instr;
    logic   valid;
    pc_t    pc;
    pc_t    pc_next;

    modport src (output instr, output valid, output pc, output pc_next);
    modport dst (input instr, input valid, input pc, input pc_next);
endinterface

// opcode group levels qualified by the 32-bit encoding
interface dec_class_if;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic op_imm;
    logic op;
    logic system;

    modport src
    (
        output lui, output auipc, output jal, output jalr, output branch,
        output load, output store, output op_imm, output op, output system
    );
    modport dst
    (
        input lui, input auipc, input jal, input jalr, input branch,
        input load, input store, input op_imm, input op, input system
    );
endinterface

//--- hw/decode/decode_reg.sv
`timescale 1ns/1ps

module decode_reg
(
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_stall,
    input  logic                    i_flush,
    input  logic                    i_ready,
    input  rv_decode_pkg::instr_t   i_instruction,
    input  rv_decode_pkg::pc_t      i_pc,
    input  rv_decode_pkg::pc_t      i_pc_next,
    dec_instr_if.src                o_dec
);

    import rv_decode_pkg::*;

    instr_t instr_masked;

    // no fetch data means a bubble
    assign instr_masked = i_ready ? i_instruction : '0;

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            o_dec.instr <= '0;
            o_dec.valid <= 1'b0;
        end
        else if (!i_stall)
        begin
            o_dec.instr   <= instr_masked;
            o_dec.valid   <= i_ready;
            o_dec.pc      <= i_pc;
            o_dec.pc_next <= i_pc_next;
        end
    end

endmodule

//--- hw/decode/opcode_decode.sv
`timescale 1ns/1ps

module opcode_decode
(
    input  logic        i_stall,
    dec_instr_if.dst    i_dec,
    dec_class_if.src    o_cls,
    output logic        o_inst_mret,
    output logic        o_inst_csr_req,
    output logic        o_inst_supported,
    output logic        o_csr_write,
    output logic        o_csr_set,
    output logic        o_csr_clear,
    output logic        o_csr_read,
    output logic        o_csr_ebreak
);

    import rv_decode_pkg::*;

    opcode_e    opcode;
    funct3_t    funct3;
    logic [11:0] funct12;
    logic       funct7_b0;
    logic       full;
    logic       ecall;
    logic       ebreak;
    logic       mret;
    logic       csr_req;

    assign opcode    = opcode_e'(i_dec.instr[6:2]);
    assign funct3    = i_dec.instr[14:12];
    assign funct12   = i_dec.instr[31:20];
    assign funct7_b0 = i_dec.instr[25];
    assign full      = (i_dec.instr[1:0] == OPC_FULL);

    assign o_cls.lui    = full & (opcode == LUI);
    assign o_cls.auipc  = full & (opcode == AUIPC);
    assign o_cls.jal    = full & (opcode == JAL);
    assign o_cls.jalr   = full & (opcode == JALR) & (funct3 == 3'b000);
    assign o_cls.branch = full & (opcode == BRANCH);
    assign o_cls.load   = full & (opcode == LOAD);
    assign o_cls.store  = full & (opcode == STORE);
    assign o_cls.op_imm = full & (opcode == OP_IMM);
    // funct7 bit 0 set would be the M extension
    assign o_cls.op     = full & (opcode == OP) & !funct7_b0;
    assign o_cls.system = full & (opcode == SYSTEM);

    // privileged forms share funct3 zero
    assign ecall   = o_cls.system & (funct3 == 3'b000) & (funct12 == 12'h000);
    assign ebreak  = o_cls.system & (funct3 == 3'b000) & (funct12 == 12'h001);
    assign mret    = o_cls.system & (funct3 == 3'b000) & (funct12 == 12'h302);
    assign csr_req = o_cls.system & (funct3 != 3'b000);

    assign o_inst_mret    = mret;
    assign o_inst_csr_req = csr_req;
    assign o_csr_read     = csr_req;
    assign o_csr_ebreak   = ebreak;

    // strobes must not fire twice while the stage is held
    assign o_csr_write = o_cls.system & (funct3[1:0] == 2'b01) & !i_stall;
    assign o_csr_set   = o_cls.system & (funct3[1:0] == 2'b10) & !i_stall;
    assign o_csr_clear = o_cls.system & (funct3[1:0] == 2'b11) & !i_stall;

    // a bubble is never flagged as illegal
    assign o_inst_supported = !i_dec.valid |
                              o_cls.load   |
                              o_cls.op     |
                              o_cls.auipc  |
                              o_cls.store  |
                              o_cls.op_imm |
                              o_cls.lui    |
                              o_cls.branch |
                              o_cls.jalr   |
                              o_cls.jal    |
                              ecall        |
                              ebreak       |
                              csr_req      |
                              mret;

endmodule

//--- hw/decode/imm_gen.sv
`timescale 1ns/1ps

module imm_gen
(
    dec_instr_if.dst                i_dec,
    dec_class_if.dst                i_cls,
    output rv_decode_pkg::imm_t     o_imm_i,
    output rv_decode_pkg::imm_t     o_imm_j
);

    import rv_decode_pkg::*;

    instr_t w;
    imm_t   imm_i;
    imm_t   imm_s;
    imm_t   imm_b;
    imm_t   imm_u;
    imm_t   imm_j;

    assign w = i_dec.instr;

    assign imm_i = {{21{w[31]}}, w[30:20]};
    assign imm_s = {{21{w[31]}}, w[30:25], w[11:7]};
    assign imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    assign imm_u = {w[31:12], 12'b0};
    assign imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};

    // operand immediate for the alu
    assign o_imm_i = (i_cls.lui | i_cls.auipc) ? imm_u :
                     i_cls.store               ? imm_s :
                                                 imm_i;

    // target offset
    assign o_imm_j = i_cls.jal ? imm_j : imm_b;

endmodule

//--- hw/decode/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl
(
    dec_instr_if.dst                    i_dec,
    dec_class_if.dst                    i_cls,
    output rv_decode_pkg::reg_idx_t     o_rs1,
    output rv_decode_pkg::alu_unit_e    o_alu_res,
    output logic                        o_alu_add_override,
    output logic                        o_alu_op1_inv,
    output logic                        o_alu_op2_inv,
    output logic                        o_alu_sh_ar,
    output rv_decode_pkg::res_src_e     o_res_src,
    output logic                        o_reg_write,
    output logic                        o_op1_src,
    output rv_decode_pkg::op2_src_e     o_op2_src,
    output logic                        o_inst_jal,
    output logic                        o_inst_jalr,
    output logic                        o_inst_branch,
    output logic                        o_inst_store
);

    import rv_decode_pkg::*;

    funct3_t funct3;
    logic    funct7_b5;
    logic    full;
    logic    arith_grp;
    logic    imm_op2;

    assign funct3    = i_dec.instr[14:12];
    assign funct7_b5 = i_dec.instr[30];
    assign full      = (i_dec.instr[1:0] == OPC_FULL);
    assign arith_grp = i_cls.op | i_cls.op_imm;

    // address and upper-immediate forms just add
    assign o_alu_add_override = i_cls.lui | i_cls.auipc | i_cls.jal |
                                i_cls.load | i_cls.store;
    assign o_alu_op1_inv = i_cls.branch & funct3[0];
    assign o_alu_sh_ar   = funct7_b5;

    // compares subtract, sub and sra take funct7 bit 5
    always_comb
    begin
        if (i_cls.branch || (arith_grp && funct3[2:1] == 2'b01))
            o_alu_op2_inv = 1'b1;
        else if (i_cls.lui || i_cls.auipc || i_cls.jal || i_cls.load ||
                 i_cls.store || i_cls.op_imm)
            o_alu_op2_inv = 1'b0;
        else
            o_alu_op2_inv = funct7_b5;
    end

    always_comb
    begin
        o_alu_res = NONE;
        if (i_cls.branch)
            o_alu_res = CMP;
        else if (i_cls.load || i_cls.store)
            o_alu_res = ARITH;
        else if (arith_grp)
        begin
            case (funct3)
                3'b000:         o_alu_res = i_cls.op ? ARITH : NONE;
                3'b001, 3'b101: o_alu_res = SHIFT;
                3'b010, 3'b011: o_alu_res = CMP;
                default:        o_alu_res = BITS;
            endcase
        end
    end

    // link address goes back through the pc_next path
    assign o_res_src = i_cls.load               ? MEMORY  :
                       (i_cls.jal | i_cls.jalr) ? PC_NEXT :
                                                  ALU;

    assign imm_op2 = i_cls.jalr | i_cls.load | i_cls.op_imm | i_cls.lui |
                     i_cls.auipc | i_cls.store;

    assign o_op2_src = i_cls.jal ? JUMP :
                       imm_op2   ? IMM  :
                                   REG;

    assign o_op1_src   = i_cls.auipc | i_cls.jal;
    assign o_reg_write = full & !i_cls.branch & !i_cls.store;

    // lui adds to x0
    assign o_rs1 = i_cls.lui ? '0 : i_dec.instr[19:15];

    assign o_inst_jal    = i_cls.jal;
    assign o_inst_jalr   = i_cls.jalr;
    assign o_inst_branch = i_cls.branch;
    assign o_inst_store  = i_cls.store;

endmodule

//--- hw/decode/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
(
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic                        i_ready,
    input  rv_decode_pkg::instr_t       i_instruction,
    input  rv_decode_pkg::pc_t          i_pc,
    input  rv_decode_pkg::pc_t          i_pc_next,
    output rv_decode_pkg::pc_t          o_pc,
    output rv_decode_pkg::pc_t          o_pc_next,
    output rv_decode_pkg::reg_idx_t     o_rs1,
    output rv_decode_pkg::reg_idx_t     o_rs2,
    output rv_decode_pkg::reg_idx_t     o_rd,
    output rv_decode_pkg::funct3_t      o_funct3,
    output rv_decode_pkg::imm_t         o_imm_i,
    output rv_decode_pkg::imm_t         o_imm_j,
    output rv_decode_pkg::alu_unit_e    o_alu_res,
    output logic                        o_alu_add_override,
    output logic                        o_alu_op1_inv,
    output logic                        o_alu_op2_inv,
    output logic                        o_alu_sh_ar,
    output rv_decode_pkg::res_src_e     o_res_src,
    output logic                        o_reg_write,
    output logic                        o_op1_src,
    output rv_decode_pkg::op2_src_e     o_op2_src,
    output logic                        o_inst_jal,
    output logic                        o_inst_jalr,
    output logic                        o_inst_branch,
    output logic                        o_inst_store,
    output logic                        o_inst_mret,
    output logic                        o_inst_csr_req,
    output logic                        o_inst_supported,
    output rv_decode_pkg::csr_idx_t     o_csr_idx,
    output rv_decode_pkg::reg_idx_t     o_csr_imm,
    output logic                        o_csr_imm_sel,
    output logic                        o_csr_write,
    output logic                        o_csr_set,
    output logic                        o_csr_clear,
    output logic                        o_csr_read,
    output logic                        o_csr_ebreak
);

    dec_instr_if instr_bus ();
    dec_class_if class_bus ();

    decode_reg u_reg
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_ready        (i_ready),
        .i_instruction  (i_instruction),
        .i_pc           (i_pc),
        .i_pc_next      (i_pc_next),
        .o_dec          (instr_bus.src)
    );

    opcode_decode u_opcode
    (
        .i_stall            (i_stall),
        .i_dec              (instr_bus.dst),
        .o_cls              (class_bus.src),
        .o_inst_mret        (o_inst_mret),
        .o_inst_csr_req     (o_inst_csr_req),
        .o_inst_supported   (o_inst_supported),
        .o_csr_write        (o_csr_write),
        .o_csr_set          (o_csr_set),
        .o_csr_clear        (o_csr_clear),
        .o_csr_read         (o_csr_read),
        .o_csr_ebreak       (o_csr_ebreak)
    );

    imm_gen u_imm
    (
        .i_dec      (instr_bus.dst),
        .i_cls      (class_bus.dst),
        .o_imm_i    (o_imm_i),
        .o_imm_j    (o_imm_j)
    );

    exec_ctrl u_exec
    (
        .i_dec                  (instr_bus.dst),
        .i_cls                  (class_bus.dst),
        .o_rs1                  (o_rs1),
        .o_alu_res              (o_alu_res),
        .o_alu_add_override     (o_alu_add_override),
        .o_alu_op1_inv          (o_alu_op1_inv),
        .o_alu_op2_inv          (o_alu_op2_inv),
        .o_alu_sh_ar            (o_alu_sh_ar),
        .o_res_src              (o_res_src),
        .o_reg_write            (o_reg_write),
        .o_op1_src              (o_op1_src),
        .o_op2_src              (o_op2_src),
        .o_inst_jal             (o_inst_jal),
        .o_inst_jalr            (o_inst_jalr),
        .o_inst_branch          (o_inst_branch),
        .o_inst_store           (o_inst_store)
    );

    // plain fields of the registered word
    assign o_pc          = instr_bus.pc;
    assign o_pc_next     = instr_bus.pc_next;
    assign o_rd          = instr_bus.instr[11:7];
    assign o_rs2         = instr_bus.instr[24:20];
    assign o_funct3      = instr_bus.instr[14:12];
    assign o_csr_idx     = instr_bus.instr[31:20];
    assign o_csr_imm     = instr_bus.instr[19:15];
    assign o_csr_imm_sel = instr_bus.instr[14];

endmodule

//--- test/decode_stage_asserts.sv
`timescale 1ns/1ps

module decode_stage_asserts
(
    input logic i_clk,
    input logic i_rst,
    input logic i_stall,
    input logic i_csr_write,
    input logic i_csr_set,
    input logic i_csr_clear,
    input logic i_supported
);

    // strobes dropped under back-pressure
    a_strobe_stall: assert property (@(posedge i_clk) disable iff (i_rst)
        i_stall |-> !(i_csr_write || i_csr_set || i_csr_clear))
        else $error("csr strobe high while the stage is stalled");

    a_strobe_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0({i_csr_write, i_csr_set, i_csr_clear}))
        else $error("more than one csr strobe high at once");

    // the reset bubble is legal
    a_supported_rst: assert property (@(posedge i_clk) i_rst |=> i_supported)
        else $error("supported low in the cycle after reset");

endmodule

bind decode_stage decode_stage_asserts u_asserts
(
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_stall        (i_stall),
    .i_csr_write    (o_csr_write),
    .i_csr_set      (o_csr_set),
    .i_csr_clear    (o_csr_clear),
    .i_supported    (o_inst_supported)
);

//--- test/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;

    import rv_decode_pkg::*;

    // tests and reset take well under a tenth of this
    localparam int TIMEOUT_CYCLES = 2000;

    logic       i_clk;
    logic       i_rst;
    logic       i_stall;
    logic       i_flush;
    logic       i_ready;
    instr_t     i_instruction;
    pc_t        i_pc;
    pc_t        i_pc_next;
    pc_t        o_pc;
    pc_t        o_pc_next;
    reg_idx_t   o_rs1;
    reg_idx_t   o_rs2;
    reg_idx_t   o_rd;
    funct3_t    o_funct3;
    imm_t       o_imm_i;
    imm_t       o_imm_j;
    alu_unit_e  o_alu_res;
    logic       o_alu_add_override;
    logic       o_alu_op1_inv;
    logic       o_alu_op2_inv;
    logic       o_alu_sh_ar;
    res_src_e   o_res_src;
    logic       o_reg_write;
    logic       o_op1_src;
    op2_src_e   o_op2_src;
    logic       o_inst_jal;
    logic       o_inst_jalr;
    logic       o_inst_branch;
    logic       o_inst_store;
    logic       o_inst_mret;
    logic       o_inst_csr_req;
    logic       o_inst_supported;
    csr_idx_t   o_csr_idx;
    reg_idx_t   o_csr_imm;
    logic       o_csr_imm_sel;
    logic       o_csr_write;
    logic       o_csr_set;
    logic       o_csr_clear;
    logic       o_csr_read;
    logic       o_csr_ebreak;

    integer     seed = 71471;
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    string      cur_test;
    pc_t        pc_cnt;

    decode_stage i_dut (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the tests did not complete", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] rnd32();
        return $random(seed);
    endfunction

    // one instruction encoder per RISC-V format
    function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input funct3_t f3,
                                     input reg_idx_t rd, input logic [4:0] opc);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input funct3_t f3, input reg_idx_t rd,
                                     input logic [4:0] opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic instr_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE, 2'b11};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] b, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input funct3_t f3);
        return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], BRANCH, 2'b11};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] u, input reg_idx_t rd,
                                     input logic [4:0] opc);
        return {u, rd, opc, 2'b11};
    endfunction

    function automatic instr_t enc_j(input logic [20:0] j, input reg_idx_t rd);
        return {j[20], j[10:1], j[11], j[19:12], rd, JAL, 2'b11};
    endfunction

    function automatic imm_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic imm_t sext13(input logic [12:0] v);
        return {{19{v[12]}}, v};
    endfunction

    function automatic imm_t sext21(input logic [20:0] v);
        return {{11{v[20]}}, v};
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_val(what, {31'd0, exp}, {31'd0, act});
    endtask

    // drive just after an edge and look once the next edge has registered it
    task automatic apply(input instr_t instr, input logic stall, input logic flush,
                         input logic ready);
        @(posedge i_clk);
        #1;
        i_instruction = instr;
        i_stall = stall;
        i_flush = flush;
        i_ready = ready;
        pc_cnt = pc_cnt + 31'd2;
        i_pc = pc_cnt;
        i_pc_next = pc_cnt + 31'd2;
        @(posedge i_clk);
        #5;
    endtask

    task automatic check_idle(input string tag);
        check_val({tag, " alu_res"}, 32'(NONE), 32'(o_alu_res));
        check_bit({tag, " supported"}, 1'b1, o_inst_supported);
        check_bit({tag, " reg_write"}, 1'b0, o_reg_write);
        check_val({tag, " flags"}, 32'd0, {25'd0, o_inst_jal, o_inst_jalr, o_inst_branch,
                  o_inst_store, o_inst_mret, o_inst_csr_req, o_csr_ebreak});
        check_val({tag, " csr strobes"}, 32'd0,
                  {28'd0, o_csr_write, o_csr_set, o_csr_clear, o_csr_read});
    endtask

    task automatic end_test(input int err_before);
        $display("test %s: %0d errors", cur_test, errors - err_before);
    endtask

    task automatic test_reset_flush();
        int err0;
        err0 = errors;
        cur_test = "reset_flush";
        check_idle("after reset");
        apply(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1, OP), 1'b0, 1'b0, 1'b1);
        check_bit("add reg_write", 1'b1, o_reg_write);
        apply(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1, OP), 1'b0, 1'b1, 1'b1);
        check_idle("after flush");
        end_test(err0);
    endtask

    task automatic run_alu(input string mn, input instr_t instr, input alu_unit_e res,
                           input logic inv, input logic ar, input op2_src_e src);
        apply(instr, 1'b0, 1'b0, 1'b1);
        check_val({mn, " alu_res"}, 32'(res), 32'(o_alu_res));
        check_bit({mn, " op2_inv"}, inv, o_alu_op2_inv);
        check_bit({mn, " sh_ar"}, ar, o_alu_sh_ar);
        check_val({mn, " op2_src"}, 32'(src), 32'(o_op2_src));
        check_val({mn, " res_src"}, 32'(ALU), 32'(o_res_src));
        check_bit({mn, " reg_write"}, 1'b1, o_reg_write);
        check_bit({mn, " supported"}, 1'b1, o_inst_supported);
    endtask

    task automatic test_alu_ops();
        int          err0;
        logic [31:0] r;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [11:0] imm;
        err0 = errors;
        cur_test = "alu_ops";
        r = rnd32();
        rd = r[4:0];
        rs1 = r[9:5];
        rs2 = r[14:10];
        imm = r[31:20];
        run_alu("add", enc_r(7'h00, rs2, rs1, 3'b000, rd, OP), ARITH, 1'b0, 1'b0, REG);
        run_alu("sub", enc_r(7'h20, rs2, rs1, 3'b000, rd, OP), ARITH, 1'b1, 1'b1, REG);
        run_alu("slt", enc_r(7'h00, rs2, rs1, 3'b010, rd, OP), CMP, 1'b1, 1'b0, REG);
        run_alu("sltu", enc_r(7'h00, rs2, rs1, 3'b011, rd, OP), CMP, 1'b1, 1'b0, REG);
        run_alu("xor", enc_r(7'h00, rs2, rs1, 3'b100, rd, OP), BITS, 1'b0, 1'b0, REG);
        run_alu("sra", enc_r(7'h20, rs2, rs1, 3'b101, rd, OP), SHIFT, 1'b1, 1'b1, REG);
        run_alu("srai", enc_i({7'h20, r[19:15]}, rs1, 3'b101, rd, OP_IMM),
                SHIFT, 1'b0, 1'b1, IMM);
        run_alu("slti", enc_i(imm, rs1, 3'b010, rd, OP_IMM), CMP, 1'b1, imm[10], IMM);
        run_alu("addi", enc_i(imm, rs1, 3'b000, rd, OP_IMM), NONE, 1'b0, imm[10], IMM);
        check_val("addi imm_i", sext12(imm), o_imm_i);
        check_val("addi rd", 32'(rd), 32'(o_rd));
        check_val("addi rs1", 32'(rs1), 32'(o_rs1));
        end_test(err0);
    endtask

    task automatic check_ctrl(input string mn, input res_src_e res, input logic op1,
                              input logic ovr, input logic [3:0] jbss, input logic wr);
        check_val({mn, " res_src"}, 32'(res), 32'(o_res_src));
        check_bit({mn, " op1_src"}, op1, o_op1_src);
        check_bit({mn, " add_override"}, ovr, o_alu_add_override);
        check_val({mn, " jal/jalr/branch/store"}, {28'd0, jbss},
                  {28'd0, o_inst_jal, o_inst_jalr, o_inst_branch, o_inst_store});
        check_bit({mn, " reg_write"}, wr, o_reg_write);
    endtask

    task automatic test_imm_ctrl();
        int          err0;
        logic [31:0] r;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [19:0] u20;
        logic [20:0] j21;
        logic [11:0] i12;
        logic [12:0] b13;
        err0 = errors;
        cur_test = "imm_ctrl";
        r = rnd32();
        rd = r[11:7];
        // keep the rs1 field of lui nonzero
        u20 = r[31:12] | 20'h00008;
        j21 = {r[20:1], 1'b0};
        apply(enc_u(u20, rd, LUI), 1'b0, 1'b0, 1'b1);
        check_val("lui imm_i", {u20, 12'd0}, o_imm_i);
        check_val("lui rs1", 32'd0, 32'(o_rs1));
        check_ctrl("lui", ALU, 1'b0, 1'b1, 4'b0000, 1'b1);
        apply(enc_u(u20, rd, AUIPC), 1'b0, 1'b0, 1'b1);
        check_val("auipc imm_i", {u20, 12'd0}, o_imm_i);
        check_ctrl("auipc", ALU, 1'b1, 1'b1, 4'b0000, 1'b1);
        apply(enc_j(j21, rd), 1'b0, 1'b0, 1'b1);
        check_val("jal imm_j", sext21(j21), o_imm_j);
        check_val("jal op2_src", 32'(JUMP), 32'(o_op2_src));
        check_ctrl("jal", PC_NEXT, 1'b1, 1'b1, 4'b1000, 1'b1);
        r = rnd32();
        i12 = r[11:0];
        b13 = {r[23:12], 1'b0};
        rs1 = r[28:24];
        rs2 = {r[31:29], r[1:0]};
        apply(enc_i(i12, rs1, 3'b000, rd, JALR), 1'b0, 1'b0, 1'b1);
        check_val("jalr imm_i", sext12(i12), o_imm_i);
        check_ctrl("jalr", PC_NEXT, 1'b0, 1'b0, 4'b0100, 1'b1);
        apply(enc_i(i12, rs1, 3'b010, rd, LOAD), 1'b0, 1'b0, 1'b1);
        check_val("lw imm_i", sext12(i12), o_imm_i);
        check_val("lw alu_res", 32'(ARITH), 32'(o_alu_res));
        check_ctrl("lw", MEMORY, 1'b0, 1'b1, 4'b0000, 1'b1);
        apply(enc_s(i12, rs2, rs1, 3'b010), 1'b0, 1'b0, 1'b1);
        check_val("sw imm_i", sext12(i12), o_imm_i);
        check_val("sw op2_src", 32'(IMM), 32'(o_op2_src));
        check_ctrl("sw", ALU, 1'b0, 1'b1, 4'b0001, 1'b0);
        apply(enc_b(b13, rs2, rs1, 3'b000), 1'b0, 1'b0, 1'b1);
        check_val("beq imm_j", sext13(b13), o_imm_j);
        check_val("beq alu_res", 32'(CMP), 32'(o_alu_res));
        check_val("beq rs2", 32'(rs2), 32'(o_rs2));
        check_bit("beq op1_inv", 1'b0, o_alu_op1_inv);
        check_bit("beq op2_inv", 1'b1, o_alu_op2_inv);
        check_ctrl("beq", ALU, 1'b0, 1'b0, 4'b0010, 1'b0);
        apply(enc_b(b13, rs2, rs1, 3'b001), 1'b0, 1'b0, 1'b1);
        check_bit("bne op1_inv", 1'b1, o_alu_op1_inv);
        check_val("bne rs1", 32'(rs1), 32'(o_rs1));
        check_val("bne funct3", 32'd1, 32'(o_funct3));
        end_test(err0);
    endtask

    // wsc is the expected write, set and clear strobes
    task automatic check_csr(input string mn, input logic [2:0] wsc, input logic sel,
                             input csr_idx_t idx, input reg_idx_t uimm);
        check_val({mn, " strobes"}, {29'd0, wsc},
                  {29'd0, o_csr_write, o_csr_set, o_csr_clear});
        check_bit({mn, " read"}, 1'b1, o_csr_read);
        check_bit({mn, " csr_req"}, 1'b1, o_inst_csr_req);
        check_bit({mn, " imm_sel"}, sel, o_csr_imm_sel);
        check_val({mn, " csr_idx"}, 32'(idx), 32'(o_csr_idx));
        check_val({mn, " csr_imm"}, 32'(uimm), 32'(o_csr_imm));
    endtask

    task automatic check_priv(input string mn, input logic [1:0] mret_ebreak);
        check_val({mn, " mret/ebreak"}, {30'd0, mret_ebreak},
                  {30'd0, o_inst_mret, o_csr_ebreak});
        check_val({mn, " csr activity"}, 32'd0,
                  {27'd0, o_inst_csr_req, o_csr_write, o_csr_set, o_csr_clear, o_csr_read});
        check_bit({mn, " supported"}, 1'b1, o_inst_supported);
    endtask

    task automatic test_system();
        int          err0;
        logic [31:0] r;
        csr_idx_t    csr;
        reg_idx_t    src;
        reg_idx_t    rd;
        err0 = errors;
        cur_test = "system";
        r = rnd32();
        csr = r[31:20];
        src = r[19:15];
        rd = r[11:7];
        apply(enc_i(csr, src, 3'b010, rd, SYSTEM), 1'b0, 1'b0, 1'b1);
        check_csr("csrrs", 3'b010, 1'b0, csr, src);
        apply(enc_i(csr, src, 3'b011, rd, SYSTEM), 1'b0, 1'b0, 1'b1);
        check_csr("csrrc", 3'b001, 1'b0, csr, src);
        apply(enc_i(csr, src, 3'b110, rd, SYSTEM), 1'b0, 1'b0, 1'b1);
        check_csr("csrrsi", 3'b010, 1'b1, csr, src);
        apply(enc_i(csr, src, 3'b001, rd, SYSTEM), 1'b0, 1'b0, 1'b1);
        check_csr("csrrw", 3'b100, 1'b0, csr, src);
        apply(enc_i(csr, src, 3'b001, rd, SYSTEM), 1'b1, 1'b0, 1'b1);
        check_csr("csrrw stalled", 3'b000, 1'b0, csr, src);
        apply(enc_i(12'h302, 5'd0, 3'b000, 5'd0, SYSTEM), 1'b0, 1'b0, 1'b1);
        check_priv("mret", 2'b10);
        apply(enc_i(12'h001, 5'd0, 3'b000, 5'd0, SYSTEM), 1'b0, 1'b0, 1'b1);
        check_priv("ebreak", 2'b01);
        apply(enc_i(12'h000, 5'd0, 3'b000, 5'd0, SYSTEM), 1'b0, 1'b0, 1'b1);
        check_priv("ecall", 2'b00);
        end_test(err0);
    endtask

    task automatic test_stall_ready();
        int          err0;
        logic [31:0] r;
        pc_t         a_pc;
        pc_t         a_pc_next;
        err0 = errors;
        cur_test = "stall_ready";
        r = rnd32();
        apply(enc_r(7'h00, r[14:10], r[9:5], 3'b100, r[4:0], OP), 1'b0, 1'b0, 1'b1);
        a_pc = i_pc;
        a_pc_next = i_pc_next;
        // a new lui waits at the input while the xor is held
        apply(enc_u(20'h00008, 5'd9, LUI), 1'b1, 1'b0, 1'b1);
        check_val("held alu_res", 32'(BITS), 32'(o_alu_res));
        check_val("held rd", 32'(r[4:0]), 32'(o_rd));
        check_val("held rs1", 32'(r[9:5]), 32'(o_rs1));
        check_val("held pc", 32'(a_pc), 32'(o_pc));
        check_val("held pc_next", 32'(a_pc_next), 32'(o_pc_next));
        check_bit("held add_override", 1'b0, o_alu_add_override);
        apply(enc_u(20'h00008, 5'd9, LUI), 1'b0, 1'b0, 1'b1);
        check_bit("released add_override", 1'b1, o_alu_add_override);
        check_val("released rs1", 32'd0, 32'(o_rs1));
        check_val("released pc", 32'(i_pc), 32'(o_pc));
        check_val("released pc_next", 32'(i_pc_next), 32'(o_pc_next));
        apply(enc_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd3, OP), 1'b0, 1'b0, 1'b0);
        check_idle("ready low");
        end_test(err0);
    endtask

    task automatic check_unsupported(input string mn, input instr_t instr);
        apply(instr, 1'b0, 1'b0, 1'b1);
        check_bit({mn, " supported"}, 1'b0, o_inst_supported);
    endtask

    task automatic test_unsupported();
        int          err0;
        logic [31:0] r;
        err0 = errors;
        cur_test = "unsupported";
        r = rnd32();
        check_unsupported("compressed", {r[31:2], 2'b01});
        check_unsupported("mul", enc_r(7'h01, r[14:10], r[9:5], 3'b000, r[4:0], OP));
        check_unsupported("fadd", enc_r(7'h00, r[14:10], r[9:5], 3'b000, r[4:0], 5'b10100));
        check_unsupported("jalr f3", enc_i(r[31:20], r[9:5], 3'b010, r[4:0], JALR));
        end_test(err0);
    endtask

    initial
    begin
        i_rst = 1'b1;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_ready = 1'b0;
        i_instruction = '0;
        i_pc = '0;
        i_pc_next = '0;
        pc_cnt = 31'h0000_0080;
        repeat (3) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        test_reset_flush();
        test_alu_ops();
        test_imm_ctrl();
        test_system();
        test_stall_ready();
        test_unsupported();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- compile.f
+incdir+common
common/rv_decode_pkg.sv
common/decode_if.sv
hw/decode/decode_reg.sv
hw/decode/opcode_decode.sv
hw/decode/imm_gen.sv
hw/decode/exec_ctrl.sv
hw/decode/decode_stage.sv
test/decode_stage_asserts.sv
test/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# build the decode stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_decode_stage \
    -Mdir obj_dir -o tb_decode_stage > build.log 2>&1 \
    && ./obj_dir/tb_decode_stage > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL: no final report"; exit 1; }
echo "PASS"
